/* design/shifter_pkg.sv */
`default_nettype none

package shifter_pkg;

    ////////////////////////////////////////
    // Widths of the shifter data path
    ////////////////////////////////////////

    localparam int DATA_WIDTH  = 16;
    localparam int SHAMT_WIDTH = 4;

    // Switch word in, shifted word out
    typedef logic [DATA_WIDTH-1:0] data_word_t;

    // Amount, low two bits from left/right buttons, high two from centre
    typedef logic [SHAMT_WIDTH-1:0] shamt_t;

    // Operation currently selected on the buttons
    typedef struct packed {
        logic   dir;     // 1 = right
        logic   rotate;  // 1 = rotate, 0 = logical shift
        shamt_t amount;
    } shift_ctrl_t;

endpackage : shifter_pkg

`default_nettype wire

/* design/display_pkg.sv */
`default_nettype none

package display_pkg;

    ////////////////////////////////////////
    // Seven-segment display
    ////////////////////////////////////////

    localparam int NUM_DIGITS = 8;
    localparam int HEX_DIGITS = 4;

    typedef logic [$clog2(NUM_DIGITS)-1:0] digit_idx_t;
    typedef logic [3:0]                    nibble_t;

    // Active low, segment a in bit 0, g in bit 6
    typedef logic [6:0]            segments_t;
    typedef logic [NUM_DIGITS-1:0] anodes_t;
    typedef logic [7:0]            led_t;

    localparam segments_t BLANK_SEGMENTS = 7'b111_1111;

    ////////////////////////////////////////
    // Buttons and timing
    ////////////////////////////////////////

    // up, down, left, right, centre
    localparam int NUM_BUTTONS = 5;

    localparam int DEBOUNCE_DIV     = 4;  // clocks per sample tick
    localparam int DEBOUNCE_SAMPLES = 3;  // equal samples to accept a level
    localparam int SCAN_DIV         = 8;  // clocks per lit digit

endpackage : display_pkg

`default_nettype wire

/* design/tick_divider.sv */
`timescale 1ns/10ps
`default_nettype none

module tick_divider
    import display_pkg::*;
(
    input  logic clk_demo,
    input  logic reset,
    output logic sample_tick,
    output logic scan_tick
);

    logic [$clog2(DEBOUNCE_DIV)-1:0] sample_cnt;
    logic [$clog2(SCAN_DIV)-1:0]     scan_cnt;

    // Debounce sample rate
    always_ff @(posedge clk_demo) begin
        if (reset) begin
            sample_cnt  <= '0;
            sample_tick <= 1'b0;
        end else begin
            sample_tick <= (sample_cnt == DEBOUNCE_DIV - 1);
            sample_cnt  <= (sample_cnt == DEBOUNCE_DIV - 1) ? '0 : sample_cnt + 1'b1;
        end
    end

    // Digit scan rate
    always_ff @(posedge clk_demo) begin
        if (reset) begin
            scan_cnt  <= '0;
            scan_tick <= 1'b0;
        end else begin
            scan_tick <= (scan_cnt == SCAN_DIV - 1);
            scan_cnt  <= (scan_cnt == SCAN_DIV - 1) ? '0 : scan_cnt + 1'b1;
        end
    end

endmodule : tick_divider

`default_nettype wire

/* design/button_conditioner.sv */
`timescale 1ns/10ps
`default_nettype none

module button_conditioner
    import display_pkg::*;
(
    input  logic clk_demo,
    input  logic reset,
    input  logic sample_tick,
    input  logic btn_raw,
    output logic press
);

    logic [1:0] sync;
    logic       accepted;
    logic       accepted_d;

    // Counts sample ticks on which the synced level differs from accepted
    logic [$clog2(DEBOUNCE_SAMPLES+1)-1:0] stable_cnt;

    // Raw button is asynchronous to clk_demo
    always_ff @(posedge clk_demo) begin
        if (reset) begin
            sync <= 2'b00;
        end else begin
            sync <= {sync[0], btn_raw};
        end
    end

    ////////////////////////////////////////
    // Stability counter
    ////////////////////////////////////////

    always_ff @(posedge clk_demo) begin
        if (reset) begin
            stable_cnt <= '0;
            accepted   <= 1'b0;
        end else if (sample_tick) begin
            if (sync[1] == accepted) begin
                stable_cnt <= '0;
            end else if (stable_cnt == DEBOUNCE_SAMPLES - 1) begin
                // Enough equal samples, take the new level
                accepted   <= sync[1];
                stable_cnt <= '0;
            end else begin
                stable_cnt <= stable_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_demo) begin
        if (reset) begin
            accepted_d <= 1'b0;
        end else begin
            accepted_d <= accepted;
        end
    end

    // Rising edge of the accepted level only
    assign press = accepted & ~accepted_d;

endmodule : button_conditioner

`default_nettype wire

/* design/shift_control.sv */
`timescale 1ns/10ps
`default_nettype none

module shift_control
    import shifter_pkg::*;
(
    input  logic        clk_demo,
    input  logic        reset,
    input  logic        press_dir,
    input  logic        press_rot,
    input  logic        press_sham0,
    input  logic        press_sham1,
    input  logic        press_advance,
    output shift_ctrl_t ctrl
);

    shift_ctrl_t ctrl_next;

    ////////////////////////////////////////
    // Next operation from press pulses
    ////////////////////////////////////////

    always_comb begin
        ctrl_next = ctrl;

        // Up and down buttons flip the flags
        if (press_dir) begin
            ctrl_next.dir = ~ctrl.dir;
        end
        if (press_rot) begin
            ctrl_next.rotate = ~ctrl.rotate;
        end

        // Left and right flip the low amount bits
        if (press_sham0) begin
            ctrl_next.amount[0] = ~ctrl.amount[0];
        end
        if (press_sham1) begin
            ctrl_next.amount[1] = ~ctrl.amount[1];
        end

        // Centre steps the high bits, 3 wraps to 0
        if (press_advance) begin
            ctrl_next.amount[3:2] = ctrl.amount[3:2] + 2'd1;
        end
    end

    always_ff @(posedge clk_demo) begin
        if (reset) begin
            ctrl <= '0;
        end else begin
            ctrl <= ctrl_next;
        end
    end

endmodule : shift_control

`default_nettype wire

/* design/barrel_shifter.sv */
`timescale 1ns/10ps
`default_nettype none

module barrel_shifter
    import shifter_pkg::*;
(
    input  logic        clk_demo,
    input  logic        reset,
    input  data_word_t  data_in,
    input  shift_ctrl_t ctrl,
    output data_word_t  data_out
);

    // One entry per stage boundary, entry 0 is the input word
    data_word_t stage [SHAMT_WIDTH+1];

    // Moves a word by a fixed number of places
    function automatic data_word_t shift_stage(
        input data_word_t word,
        input int         places,
        input logic       right,
        input logic       rotate
    );
        data_word_t moved;
        data_word_t wrapped;
        if (right) begin
            moved   = word >> places;
            wrapped = word << (DATA_WIDTH - places);
        end else begin
            moved   = word << places;
            wrapped = word >> (DATA_WIDTH - places);
        end
        // Rotate puts the bits pushed out back in at the far end
        return rotate ? (moved | wrapped) : moved;
    endfunction

    ////////////////////////////////////////
    // Stages of 1, 2, 4 and 8 places
    ////////////////////////////////////////

    assign stage[0] = data_in;

    for (genvar s = 0; s < SHAMT_WIDTH; s++) begin : g_stage
        assign stage[s+1] = ctrl.amount[s]
                          ? shift_stage(stage[s], 1 << s, ctrl.dir, ctrl.rotate)
                          : stage[s];
    end

    always_ff @(posedge clk_demo) begin
        if (reset) begin
            data_out <= '0;
        end else begin
            data_out <= stage[SHAMT_WIDTH];
        end
    end

endmodule : barrel_shifter

`default_nettype wire

/* design/hex_display_scanner.sv */
`timescale 1ns/10ps
`default_nettype none

module hex_display_scanner
    import shifter_pkg::*;
    import display_pkg::*;
(
    input  logic       clk_demo,
    input  logic       reset,
    input  logic       scan_tick,
    input  data_word_t value,
    output segments_t  seg,
    output anodes_t    an
);

    digit_idx_t digit_idx;
    nibble_t    nibble;
    segments_t  digit_segments;

    // Hex glyphs, active low, a in bit 0
    function automatic segments_t hex_to_segments(input nibble_t hex);
        case (hex)
            4'h0: return 7'h40;
            4'h1: return 7'h79;
            4'h2: return 7'h24;
            4'h3: return 7'h30;
            4'h4: return 7'h19;
            4'h5: return 7'h12;
            4'h6: return 7'h02;
            4'h7: return 7'h78;
            4'h8: return 7'h00;
            4'h9: return 7'h10;
            4'ha: return 7'h08;
            4'hb: return 7'h03;
            4'hc: return 7'h46;
            4'hd: return 7'h21;
            4'he: return 7'h06;
            default: return 7'h0e;
        endcase
    endfunction

    ////////////////////////////////////////
    // Glyph for the current digit
    ////////////////////////////////////////

    // Digit i shows bits 4i+3..4i
    assign nibble = nibble_t'(value >> {digit_idx, 2'b00});

    // Upper digits stay dark
    assign digit_segments = (digit_idx >= HEX_DIGITS) ? BLANK_SEGMENTS
                                                      : hex_to_segments(nibble);

    ////////////////////////////////////////
    // Scan registers
    ////////////////////////////////////////

    always_ff @(posedge clk_demo) begin
        if (reset) begin
            digit_idx <= '0;
            an        <= '1;
            seg       <= BLANK_SEGMENTS;
        end else if (scan_tick) begin
            // One-cold anode for the digit being shown
            an  <= ~(anodes_t'(1) << digit_idx);
            seg <= digit_segments;
            if (digit_idx == NUM_DIGITS - 1) begin
                digit_idx <= '0;
            end else begin
                digit_idx <= digit_idx + 1'b1;
            end
        end
    end

endmodule : hex_display_scanner

`default_nettype wire

/* design/shifter_display_top.sv */
`timescale 1ns/10ps
`default_nettype none

module shifter_display_top
    import shifter_pkg::*;
    import display_pkg::*;
(
    input  logic                   clk_demo,
    input  logic                   reset,
    input  data_word_t             sw,
    input  logic [NUM_BUTTONS-1:0] btn,
    output led_t                   led,
    output segments_t              seg,
    output anodes_t                an
);

    logic                   sample_tick;
    logic                   scan_tick;
    logic [NUM_BUTTONS-1:0] press;
    shift_ctrl_t            ctrl;
    data_word_t             result;

    tick_divider u_tick_divider (
        .clk_demo    (clk_demo),
        .reset       (reset),
        .sample_tick (sample_tick),
        .scan_tick   (scan_tick)
    );

    ////////////////////////////////////////
    // Buttons: up, down, left, right, centre
    ////////////////////////////////////////

    for (genvar b = 0; b < NUM_BUTTONS; b++) begin : g_button
        button_conditioner u_button_conditioner (
            .clk_demo    (clk_demo),
            .reset       (reset),
            .sample_tick (sample_tick),
            .btn_raw     (btn[b]),
            .press       (press[b])
        );
    end

    shift_control u_shift_control (
        .clk_demo      (clk_demo),
        .reset         (reset),
        .press_dir     (press[0]),
        .press_rot     (press[1]),
        .press_sham0   (press[2]),
        .press_sham1   (press[3]),
        .press_advance (press[4]),
        .ctrl          (ctrl)
    );

    barrel_shifter u_barrel_shifter (
        .clk_demo (clk_demo),
        .reset    (reset),
        .data_in  (sw),
        .ctrl     (ctrl),
        .data_out (result)
    );

    hex_display_scanner u_hex_display_scanner (
        .clk_demo  (clk_demo),
        .reset     (reset),
        .scan_tick (scan_tick),
        .value     (result),
        .seg       (seg),
        .an        (an)
    );

    // Amount on the top four LEDs, then rotate and direction
    assign led = {ctrl.amount, ctrl.rotate, ctrl.dir, 2'b00};

endmodule : shifter_display_top

`default_nettype wire

/* tests/shifter_display_checker.sv */
`timescale 1ns/10ps
`default_nettype none

module shifter_display_checker
    import display_pkg::*;
(
    input logic      clk_demo,
    input logic      reset,
    input anodes_t   an,
    input segments_t seg,
    input logic      press
);

    // At most one digit lit at a time
    one_anode_low: assert property (
        @(posedge clk_demo) disable iff (reset) $countones(~an) <= 1
    ) else $error("more than one anode low: %b", an);

    // Press is a single-cycle pulse
    press_single_cycle: assert property (
        @(posedge clk_demo) disable iff (reset) press |=> !press
    ) else $error("press held high for two cycles");

    upper_digits_blank: assert property (
        @(posedge clk_demo) disable iff (reset)
            (an[NUM_DIGITS-1:HEX_DIGITS] != '1) |-> (seg == BLANK_SEGMENTS)
    ) else $error("upper digit lit with segments %b", seg);

endmodule : shifter_display_checker

////////////////////////////////////////
// Attachment points
////////////////////////////////////////

// Scanner has no press pulse
bind hex_display_scanner shifter_display_checker u_scan_checker (
    .clk_demo (clk_demo),
    .reset    (reset),
    .an       (an),
    .seg      (seg),
    .press    (1'b0)
);

// Conditioners drive no display
bind button_conditioner shifter_display_checker u_press_checker (
    .clk_demo (clk_demo),
    .reset    (reset),
    .an       ('1),
    .seg      (BLANK_SEGMENTS),
    .press    (press)
);

`default_nettype wire

/* tests/shifter_display_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module shifter_display_tb
    import shifter_pkg::*;
    import display_pkg::*;
();

    localparam int PRESS_CYCLES = 20;
    localparam int RESET_CYCLES = 16;
    localparam int GLITCH_GAP   = 16;
    localparam int SCAN_LIMIT   = 2 * NUM_DIGITS * SCAN_DIV + 4;
    localparam int MAX_TESTS    = 32;

    // Button order on the board
    localparam int BTN_UP     = 0;
    localparam int BTN_DOWN   = 1;
    localparam int BTN_LEFT   = 2;
    localparam int BTN_RIGHT  = 3;
    localparam int BTN_CENTRE = 4;

    typedef struct packed {
        data_word_t sw;
        shift_ctrl_t target;
        data_word_t expected;
    } stim_t;

    logic                   clk_demo = 1'b0;
    logic                   reset;
    data_word_t             sw;
    logic [NUM_BUTTONS-1:0] btn;
    led_t                   led;
    segments_t              seg;
    anodes_t                an;

    stim_t       stim [MAX_TESTS];
    string       stim_name [MAX_TESTS];
    int          num_tests    = 0;
    bit          stim_loaded  = 1'b0;
    shift_ctrl_t model_ctrl   = '0;
    segments_t   shown [NUM_DIGITS];
    logic [31:0] lfsr_state   = 32'hd850354f;
    bit          test_failed  = 1'b0;
    int          tests_passed = 0;
    int          tests_failed = 0;
    int          other_errors = 0;

    shifter_display_top uut (
        .clk_demo (clk_demo),
        .reset    (reset),
        .sw       (sw),
        .btn      (btn),
        .led      (led),
        .seg      (seg),
        .an       (an)
    );

    always #2 clk_demo = ~clk_demo;

    ////////////////////////////////////////
    // Reference models
    ////////////////////////////////////////

    // Shift rule, one output bit at a time
    function automatic data_word_t expected_shift(input data_word_t word, input shift_ctrl_t op);
        data_word_t result;
        int         k;
        int         src;
        result = '0;
        k      = int'(op.amount);
        for (int i = 0; i < DATA_WIDTH; i++) begin
            src = op.dir ? i + k : i - k;
            if (src >= 0 && src < DATA_WIDTH) begin
                result[i] = word[src];
            end else if (op.rotate) begin
                result[i] = word[(src + DATA_WIDTH) % DATA_WIDTH];
            end
        end
        return result;
    endfunction

    // Amount on bits 7:4, rotate on 3, direction on 2, low bits dark
    function automatic led_t expected_led(input shift_ctrl_t op);
        return {op.amount, op.rotate, op.dir, 2'b00};
    endfunction

    // Glyph back to {valid, nibble}
    function automatic logic [4:0] glyph_value(input segments_t glyph);
        case (glyph)
            7'h40: return 5'h10;
            7'h79: return 5'h11;
            7'h24: return 5'h12;
            7'h30: return 5'h13;
            7'h19: return 5'h14;
            7'h12: return 5'h15;
            7'h02: return 5'h16;
            7'h78: return 5'h17;
            7'h00: return 5'h18;
            7'h10: return 5'h19;
            7'h08: return 5'h1a;
            7'h03: return 5'h1b;
            7'h46: return 5'h1c;
            7'h21: return 5'h1d;
            7'h06: return 5'h1e;
            7'h0e: return 5'h1f;
            default: return 5'h00;
        endcase
    endfunction

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_bits(input int count, output int value);
        value = 0;
        for (int i = 0; i < count; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value      = (value << 1) | int'(lfsr_state[0]);
        end
    endtask

    ////////////////////////////////////////
    // Checks
    ////////////////////////////////////////

    task automatic check_word(input string name, input data_word_t expected,
                              input data_word_t actual);
        if (actual !== expected) begin
            $display("FAILED %s: expected %h, actual %h", name, expected, actual);
            test_failed = 1'b1;
        end
    endtask

    task automatic check_led(input string name, input led_t expected, input led_t actual);
        if (actual !== expected) begin
            $display("FAILED %s led: expected %b, actual %b", name, expected, actual);
            test_failed = 1'b1;
        end
    endtask

    task automatic check_segments(input string name, input segments_t expected,
                                  input segments_t actual);
        if (actual !== expected) begin
            $display("FAILED %s: expected %b, actual %b", name, expected, actual);
            test_failed = 1'b1;
        end
    endtask

    ////////////////////////////////////////
    // Stimulus and capture
    ////////////////////////////////////////

    task automatic press_button(input int b);
        @(posedge clk_demo);
        btn[b] <= 1'b1;
        repeat (PRESS_CYCLES) @(posedge clk_demo);
        btn[b] <= 1'b0;
        repeat (PRESS_CYCLES) @(posedge clk_demo);
    endtask

    // Press until the model matches the target
    task automatic apply_controls(input shift_ctrl_t target);
        if (model_ctrl.dir != target.dir) begin
            press_button(BTN_UP);
            model_ctrl.dir = ~model_ctrl.dir;
        end
        if (model_ctrl.rotate != target.rotate) begin
            press_button(BTN_DOWN);
            model_ctrl.rotate = ~model_ctrl.rotate;
        end
        if (model_ctrl.amount[0] != target.amount[0]) begin
            press_button(BTN_LEFT);
            model_ctrl.amount[0] = ~model_ctrl.amount[0];
        end
        if (model_ctrl.amount[1] != target.amount[1]) begin
            press_button(BTN_RIGHT);
            model_ctrl.amount[1] = ~model_ctrl.amount[1];
        end
        while (model_ctrl.amount[3:2] != target.amount[3:2]) begin
            press_button(BTN_CENTRE);
            model_ctrl.amount[3:2] = model_ctrl.amount[3:2] + 2'd1;
        end
    endtask

    task automatic read_display(input string name, output data_word_t word);
        anodes_t               prev_an;
        logic [NUM_DIGITS-1:0] seen;
        logic [4:0]            decoded;
        int                    waited;
        seen   = '0;
        waited = 0;
        word   = '0;
        @(negedge clk_demo);
        prev_an = an;
        while (seen != '1 && waited < SCAN_LIMIT) begin
            @(negedge clk_demo);
            waited++;
            for (int i = 0; i < NUM_DIGITS; i++) begin
                // Only a fresh activation carries the settled value
                if (!an[i] && prev_an[i]) begin
                    shown[i] = seg;
                    seen[i]  = 1'b1;
                end
            end
            prev_an = an;
        end
        if (seen != '1) begin
            $display("%s: the display did not light every digit in %0d cycles", name, SCAN_LIMIT);
            test_failed = 1'b1;
        end
        for (int i = 0; i < HEX_DIGITS; i++) begin
            decoded = glyph_value(shown[i]);
            if (!decoded[4]) begin
                $display("%s: digit %0d shows no hex glyph (%b)", name, i, shown[i]);
                test_failed = 1'b1;
            end
            word[4*i +: 4] = decoded[3:0];
        end
        for (int i = HEX_DIGITS; i < NUM_DIGITS; i++) begin
            check_segments($sformatf("%s digit %0d", name, i), BLANK_SEGMENTS, shown[i]);
        end
    endtask

    task automatic verify_state(input string name, input data_word_t expected);
        data_word_t word;
        @(negedge clk_demo);
        check_led(name, expected_led(model_ctrl), led);
        read_display(name, word);
        check_word(name, expected, word);
    endtask

    task automatic close_test(input string name);
        if (test_failed) begin
            tests_failed++;
        end else begin
            tests_passed++;
            $display("PASS %s", name);
        end
        test_failed = 1'b0;
    endtask

    ////////////////////////////////////////
    // Tests
    ////////////////////////////////////////

    task automatic run_file_test(input int idx);
        stim_t t;
        t = stim[idx];
        // File value must agree with the shift rule
        check_word({stim_name[idx], " rule"}, t.expected, expected_shift(t.sw, t.target));
        @(posedge clk_demo);
        sw <= t.sw;
        apply_controls(t.target);
        repeat (2) @(posedge clk_demo);
        verify_state(stim_name[idx], t.expected);
        close_test(stim_name[idx]);
    endtask

    // Four centre steps bring the high amount bits back
    task automatic run_wrap_test();
        for (int n = 0; n < 4; n++) begin
            press_button(BTN_CENTRE);
            model_ctrl.amount[3:2] = model_ctrl.amount[3:2] + 2'd1;
            @(negedge clk_demo);
            check_led($sformatf("WRAP step %0d", n), expected_led(model_ctrl), led);
        end
        verify_state("WRAP", expected_shift(sw, model_ctrl));
        close_test("WRAP");
    endtask

    task automatic run_bounce_test();
        int len;
        for (int b = 0; b < NUM_BUTTONS; b++) begin
            for (int g = 0; g < 3; g++) begin
                draw_bits(2, len);
                @(posedge clk_demo);
                btn[b] <= 1'b1;
                repeat (len + 1) @(posedge clk_demo);
                btn[b] <= 1'b0;
                repeat (GLITCH_GAP) @(posedge clk_demo);
            end
        end
        repeat (PRESS_CYCLES) @(posedge clk_demo);
        verify_state("BOUNCE", expected_shift(sw, model_ctrl));
        close_test("BOUNCE");
    endtask

    initial begin : main
        int          fd;
        int          code;
        string       token;
        string       rest;
        data_word_t  f_sw;
        data_word_t  f_exp;
        logic        f_dir;
        logic        f_rot;
        shamt_t      f_amt;
        sw    = '0;
        btn   = '0;
        reset = 1'b1;
        fd = $fopen("tests/shifter_stim.dat", "r");
        if (fd == 0) begin
            $display("Could not open tests/shifter_stim.dat");
            other_errors++;
        end else begin
            while (num_tests < MAX_TESTS && $fscanf(fd, "%s", token) == 1) begin
                if (token.substr(0, 0) == "#") begin
                    code = $fgets(rest, fd);
                end else begin
                    code = $fscanf(fd, "%h %h %h %h %h", f_sw, f_dir, f_rot, f_amt, f_exp);
                    if (code != 5) begin
                        $display("Stimulus line %s is malformed", token);
                        other_errors++;
                        break;
                    end
                    stim_name[num_tests] = token;
                    stim[num_tests]      = {f_sw, f_dir, f_rot, f_amt, f_exp};
                    num_tests++;
                end
            end
            $fclose(fd);
        end
        if (num_tests == 0) begin
            $display("No test vectors were read from the stimulus file");
            other_errors++;
        end
        stim_loaded = 1'b1;

        repeat (RESET_CYCLES) @(posedge clk_demo);
        reset <= 1'b0;

        for (int i = 0; i < num_tests; i++) begin
            run_file_test(i);
        end
        run_wrap_test();
        run_bounce_test();

        $display("Tests passed %0d, failed %0d, other errors %0d",
                 tests_passed, tests_failed, other_errors);
        if (tests_failed == 0 && other_errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    // Ten presses per test plus four full scans, doubled
    initial begin : watchdog
        int limit;
        wait (stim_loaded);
        limit = 2 * ((num_tests + 2) * 10 * 2 * PRESS_CYCLES + 4 * NUM_DIGITS * SCAN_DIV)
              + RESET_CYCLES;
        repeat (limit) @(posedge clk_demo);
        $display("The run timed out after %0d cycles", limit);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule : shifter_display_tb

`default_nettype wire

/* tests/shifter_stim.dat */
# name  sw  dir  rotate  amount  expected, all fields hex
# dir 1 = right, rotate 1 = rotate; controls are targets reached by button presses
RST0 a5c3 0 0 0 a5c3
SHL1 a5c3 0 0 1 4b86
SHL4 1234 0 0 4 2340
SHL7 00ff 0 0 7 7f80
SHLC f00d 0 0 c d000
SHL9 0f0f 0 0 9 1e00
SHR3 8000 1 0 3 1000
SHR5 ffff 1 0 5 07ff
SHRA beef 1 0 a 002f
SHRF 9abc 1 0 f 0001
ROL0 c0de 0 1 0 c0de
ROL3 8001 0 1 3 000c
ROL8 1234 0 1 8 3412
ROLB 5a5a 0 1 b d2d2
ROLF abcd 0 1 f d5e6
ROR1 0001 1 1 1 8000
ROR4 1234 1 1 4 4123
ROR8 beef 1 1 8 efbe
RORF 8421 1 1 f 0843

/* project.f */
design/shifter_pkg.sv
design/display_pkg.sv
design/tick_divider.sv
design/button_conditioner.sv
design/shift_control.sv
design/barrel_shifter.sv
design/hex_display_scanner.sv
design/shifter_display_top.sv
tests/shifter_display_checker.sv
tests/shifter_display_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal -j 0
TOP       = shifter_display_tb
FILELIST  = project.f
OBJ_DIR   = obj_dir
PASS_MSG  = Simulation finished: PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
